// ==== Makefile ====
# Verilator build and run for the AXI write master testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module tb_axi_master_wr \
		--Mdir obj_dir -o Vtb_axi_master_wr

run: compile
	./obj_dir/Vtb_axi_master_wr | tee $(LOG)
	@grep -q "Done: no errors" $(LOG) || (echo "simulation failed"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/axi_wr_mem_model.sv ====
// ----------------------------------------------------------------------
// AXI write slave model
// Random AW and W ready stalls, word memory, AW address log
// One scripted error response by absolute response index
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_wr_mem_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [axi_wr_pkg::ADDR_W-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [axi_wr_pkg::DATA_W-1:0] wdata,
    input  logic                          wlast,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [axi_wr_pkg::ID_W-1:0]   bid,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  int                            err_resp
);

    integer seed = 32'h40ae_66f8;

    logic [axi_wr_pkg::DATA_W-1:0] mem [0:8191];
    logic [axi_wr_pkg::ADDR_W-1:0] aw_q [$];
    logic [axi_wr_pkg::ADDR_W-1:0] aw_log [$];
    logic [axi_wr_pkg::DATA_W-1:0] w_q [$];

    int beat_in_burst = 0;
    int commit_pos    = 0;
    int pending       = 0;
    int resp_n        = 0;
    int beats_seen    = 0;
    int wlast_bad     = 0;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= axi_wr_pkg::AXI_RESP_OKAY;
            bid     <= '0;
        end
        else
        begin
            if (awvalid && awready)
            begin
                aw_q.push_back(awaddr);
                aw_log.push_back(awaddr);
            end
            if (wvalid && wready)
            begin
                if (wlast != (beat_in_burst == 3))
                    wlast_bad++;
                beat_in_burst = (beat_in_burst + 1) % 4;
                beats_seen++;
                w_q.push_back(wdata);
            end
            // Pair W beats with burst addresses, W may lead AW
            while (aw_q.size() > 0 && w_q.size() > 0)
            begin
                mem[13'((aw_q[0] >> 3) + 64'(commit_pos))] = w_q.pop_front();
                commit_pos++;
                if (commit_pos == 4)
                begin
                    commit_pos = 0;
                    void'(aw_q.pop_front());
                    pending++;
                end
            end
            if (bvalid && bready)
            begin
                resp_n++;
                pending--;
            end
            bvalid  <= pending > 0;
            bresp   <= (resp_n == err_resp) ? 2'b10 : axi_wr_pkg::AXI_RESP_OKAY;
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 3) != 0;
        end
    end

endmodule

// ==== dv/tb_axi_master_wr.sv ====
// ----------------------------------------------------------------------
// Testbench for the AXI write master
// Clock, reset, random show-ahead FIFO source, job table, checks
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_axi_master_wr;

    typedef struct {
        string                         name;
        logic [axi_wr_pkg::ADDR_W-1:0] base;
        int                            w;
        int                            h;
        int                            err;
        int                            poke;
        int                            exp_done;
        int                            exp_err;
    } test_row_t;

    logic clk;
    logic rst_n;
    logic start_pulse;
    logic [axi_wr_pkg::ADDR_W-1:0] target_address;
    logic [axi_wr_pkg::GRID_W-1:0] blk_w;
    logic [axi_wr_pkg::GRID_W-1:0] blk_h;
    logic fifo_empty;
    logic [axi_wr_pkg::DATA_W-1:0] fifo_dout;
    logic fifo_rd;
    logic fifo_popped;
    logic [axi_wr_pkg::ID_W-1:0] awid;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic [3:0] awcache;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [axi_wr_pkg::ID_W-1:0] bid;
    logic [1:0] bresp;
    axi_wr_pkg::aw_beat_t aw;
    logic [axi_wr_pkg::DATA_W-1:0] wdata;
    logic [axi_wr_pkg::STRB_W-1:0] wstrb;
    logic done_pulse, wr_error;

    test_row_t tests [6];
    integer seed = 32'h40ae_66f8;
    int err_resp = -1;
    int errors = 0;
    int fifo_seq = 0;
    int done_cnt = 0;
    int err_cnt = 0;
    int cycles = 0;
    int limit = 0;
    string cur_name = "";

    axi_master_wr DUT (
        .clk(clk), .rst_n(rst_n), .start_pulse(start_pulse),
        .target_address(target_address), .blk_w(blk_w), .blk_h(blk_h),
        .fifo_empty(fifo_empty), .fifo_dout(fifo_dout), .fifo_rd(fifo_rd),
        .m_axi_awid(awid), .m_axi_awaddr(aw.awaddr), .m_axi_awlen(aw.awlen),
        .m_axi_awsize(awsize), .m_axi_awburst(awburst), .m_axi_awcache(awcache),
        .m_axi_awvalid(awvalid), .m_axi_awready(awready),
        .m_axi_wdata(wdata), .m_axi_wstrb(wstrb), .m_axi_wlast(wlast),
        .m_axi_wvalid(wvalid), .m_axi_wready(wready),
        .m_axi_bid(bid), .m_axi_bresp(bresp), .m_axi_bvalid(bvalid),
        .m_axi_bready(bready), .done_pulse(done_pulse), .wr_error(wr_error)
    );

    axi_wr_mem_model MEM (
        .clk(clk), .rst_n(rst_n), .awaddr(aw.awaddr), .awvalid(awvalid),
        .awready(awready), .wdata(wdata), .wlast(wlast), .wvalid(wvalid),
        .wready(wready), .bid(bid), .bresp(bresp), .bvalid(bvalid),
        .bready(bready), .err_resp(err_resp)
    );

    // Expected FIFO word for a stream position
    function automatic logic [axi_wr_pkg::DATA_W-1:0] word_at(input int seq);
        return 64'hC0DE_0000_0000_0000 | 64'(seq);
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Show-ahead FIFO source with random empty cycles
    // ------------------------------------------------------------------
    assign fifo_dout = word_at(fifo_seq);

    always @(posedge clk)
    begin
        fifo_popped = fifo_rd;
        if (fifo_rd)
            fifo_seq <= fifo_seq + 1;
        #1;
        // A shown word stays until it is popped
        if (fifo_empty || fifo_popped)
            fifo_empty = ($random(seed) & 7) == 0;
    end

    always @(posedge clk)
    begin
        if (done_pulse)
            done_cnt <= done_cnt + 1;
        if (wr_error)
            err_cnt <= err_cnt + 1;
    end

    // Fixed AXI fields on every AW and W transfer
    always @(posedge clk)
    begin
        if (rst_n && awvalid && awready)
        begin
            compare_code({cur_name, " awid"}, 8'd0, 8'(awid));
            compare_code({cur_name, " awlen"}, 8'd3, aw.awlen);
            compare_code({cur_name, " awsize"}, 8'd3, 8'(awsize));
            compare_code({cur_name, " awburst"}, 8'd1, 8'(awburst));
            compare_code({cur_name, " awcache"}, 8'd3, 8'(awcache));
        end
        if (rst_n && wvalid && wready)
            compare_code({cur_name, " wstrb"}, 8'hFF, 8'(wstrb));
    end

    // Watchdog
    initial
    begin
        @(posedge clk);
        while (cycles <= limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles without finishing", limit);
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic compare_addr(input string name, input logic [axi_wr_pkg::ADDR_W-1:0] exp,
                                input logic [axi_wr_pkg::ADDR_W-1:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("mismatch %s: address expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_data(input string name, input logic [axi_wr_pkg::DATA_W-1:0] exp,
                                input logic [axi_wr_pkg::DATA_W-1:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("mismatch %s: data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input logic [axi_wr_pkg::CNT_W-1:0] exp,
                                 input logic [axi_wr_pkg::CNT_W-1:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("mismatch %s: count expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_code(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("mismatch %s: code expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic pulse_start(input logic [axi_wr_pkg::ADDR_W-1:0] base, input int w,
                               input int h);
        @(posedge clk);
        #1;
        start_pulse    = 1'b1;
        target_address = base;
        blk_w          = axi_wr_pkg::GRID_W'(w);
        blk_h          = axi_wr_pkg::GRID_W'(h);
        @(posedge clk);
        #1 start_pulse = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Job table loop
    // ------------------------------------------------------------------
    task automatic run_row(input test_row_t t);
        int seq0, aw0, beats0, done0, err0, bursts, first_err, waited;
        cur_name  = t.name;
        seq0      = fifo_seq;
        aw0       = MEM.aw_log.size();
        beats0    = MEM.beats_seen;
        done0     = done_cnt;
        err0      = err_cnt;
        first_err = errors;
        bursts    = t.exp_done ? t.w * t.h : 0;
        waited    = 0;
        err_resp  = (t.err < 0) ? -1 : MEM.resp_n + t.err;
        pulse_start(t.base, t.w, t.h);
        if (t.poke)
        begin
            repeat (2) @(posedge clk);
            pulse_start(t.base + 64'h1000, 1, 1);
        end
        if (t.exp_done == 0)
            repeat (50) @(posedge clk);
        else
        begin
            while (done_cnt == done0)
                @(posedge clk);
            repeat (10) @(posedge clk);
        end
        compare_count({t.name, " done"}, 20'(t.exp_done), 20'(done_cnt - done0));
        compare_count({t.name, " wr_error"}, 20'(t.exp_err), 20'(err_cnt - err0));
        compare_count({t.name, " bursts"}, 20'(bursts), 20'(MEM.aw_log.size() - aw0));
        compare_count({t.name, " beats"}, 20'(bursts * 4), 20'(MEM.beats_seen - beats0));
        for (int k = 0; k < bursts && aw0 + k < MEM.aw_log.size(); k++)
            compare_addr(t.name, t.base + 64'(32 * k), MEM.aw_log[aw0 + k]);
        for (int k = 0; k < bursts * 4; k++)
            compare_data(t.name, word_at(seq0 + k), MEM.mem[13'((t.base >> 3) + 64'(k))]);
        if (errors == first_err)
            $display("test %s: ok", t.name);
        else
            $display("test %s: failed with %0d errors", t.name, errors - first_err);
    endtask

    initial
    begin
        int total_beats;
        rst_n          = 1'b0;
        start_pulse    = 1'b0;
        target_address = '0;
        blk_w          = '0;
        blk_h          = '0;
        fifo_empty     = 1'b1;
        total_beats    = 0;
        //          name        base       w  h  err poke done errs
        tests[0] = '{"single",  64'h1000, 1, 1, -1, 0, 1, 0};
        tests[1] = '{"grid",    64'h2000, 3, 2, -1, 0, 1, 0};
        tests[2] = '{"stalls",  64'h3000, 4, 4, -1, 0, 1, 0};
        tests[3] = '{"slverr",  64'h4000, 2, 2, 2,  0, 1, 1};
        tests[4] = '{"zero",    64'h5000, 0, 3, -1, 0, 0, 0};
        tests[5] = '{"retrig",  64'h6000, 2, 1, -1, 1, 1, 0};
        foreach (tests[i])
            total_beats += tests[i].w * tests[i].h * 4;
        limit = total_beats * 20 + 200;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (tests[i])
            run_row(tests[i]);
        compare_count("wlast", 20'd0, 20'(MEM.wlast_bad));
        $display("tests %0d, errors %0d", $size(tests), errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== hdl/axi_master_wr.sv ====
// ----------------------------------------------------------------------
// AXI4 write master top level
// Job decode, AW and W execute blocks, B response tracker
// Constant AXI sideband fields
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_master_wr (
    input  logic                          clk,
    input  logic                          rst_n,

    // Local job control
    input  logic                          start_pulse,
    input  logic [axi_wr_pkg::ADDR_W-1:0] target_address,
    input  logic [axi_wr_pkg::GRID_W-1:0] blk_w,
    input  logic [axi_wr_pkg::GRID_W-1:0] blk_h,

    // Result FIFO, show-ahead
    input  logic                          fifo_empty,
    input  logic [axi_wr_pkg::DATA_W-1:0] fifo_dout,
    output logic                          fifo_rd,

    // AW channel
    output logic [axi_wr_pkg::ID_W-1:0]   m_axi_awid,
    output logic [axi_wr_pkg::ADDR_W-1:0] m_axi_awaddr,
    output logic [7:0]                    m_axi_awlen,
    output logic [2:0]                    m_axi_awsize,
    output logic [1:0]                    m_axi_awburst,
    output logic [3:0]                    m_axi_awcache,
    output logic                          m_axi_awvalid,
    input  logic                          m_axi_awready,

    // W channel
    output logic [axi_wr_pkg::DATA_W-1:0] m_axi_wdata,
    output logic [axi_wr_pkg::STRB_W-1:0] m_axi_wstrb,
    output logic                          m_axi_wlast,
    output logic                          m_axi_wvalid,
    input  logic                          m_axi_wready,

    // B channel
    input  logic [axi_wr_pkg::ID_W-1:0]   m_axi_bid,
    input  logic [1:0]                    m_axi_bresp,
    input  logic                          m_axi_bvalid,
    output logic                          m_axi_bready,

    // Status
    output logic                          done_pulse,
    output logic                          wr_error
);

    axi_wr_pkg::job_plan_t plan;
    logic                  plan_start;
    logic                  busy;
    axi_wr_pkg::aw_beat_t  aw;
    axi_wr_pkg::b_resp_t   b;

    // ------------------------------------------------------------------
    // Sideband and struct packing
    // ------------------------------------------------------------------
    assign m_axi_awid    = '0;
    assign m_axi_awsize  = axi_wr_pkg::AWSIZE_VAL;
    assign m_axi_awburst = axi_wr_pkg::AXI_BURST_INCR;
    assign m_axi_awcache = axi_wr_pkg::AXI_CACHE_BUF;
    assign m_axi_bready  = 1'b1;

    assign m_axi_awaddr  = aw.awaddr;
    assign m_axi_awlen   = aw.awlen;
    assign b.bid         = m_axi_bid;
    assign b.bresp       = m_axi_bresp;

    // ------------------------------------------------------------------
    // Decode, execute and result
    // ------------------------------------------------------------------
    wr_job_decode u_wr_job_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_pulse    (start_pulse),
        .target_address (target_address),
        .blk_w          (blk_w),
        .blk_h          (blk_h),
        .busy           (busy),
        .plan           (plan),
        .plan_start     (plan_start)
    );

    waddr_channel u_waddr_channel (
        .clk        (clk),
        .rst_n      (rst_n),
        .plan       (plan),
        .plan_start (plan_start),
        .aw         (aw),
        .awvalid    (m_axi_awvalid),
        .awready    (m_axi_awready)
    );

    wdata_channel u_wdata_channel (
        .clk        (clk),
        .rst_n      (rst_n),
        .plan       (plan),
        .plan_start (plan_start),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .fifo_rd    (fifo_rd),
        .wdata      (m_axi_wdata),
        .wstrb      (m_axi_wstrb),
        .wlast      (m_axi_wlast),
        .wvalid     (m_axi_wvalid),
        .wready     (m_axi_wready)
    );

    wresp_tracker u_wresp_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .plan       (plan),
        .plan_start (plan_start),
        .b          (b),
        .bvalid     (m_axi_bvalid),
        .busy       (busy),
        .done_pulse (done_pulse),
        .wr_error   (wr_error)
    );

endmodule

// ==== hdl/axi_wr_pkg.sv ====
// ----------------------------------------------------------------------
// Shared widths, AXI codes and burst geometry for the AXI write master
// Job plan, AW payload and B response structs
// ----------------------------------------------------------------------

package axi_wr_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 2;
    localparam int GRID_W = 10;
    localparam int CNT_W  = 20;

    // ------------------------------------------------------------------
    // Burst geometry, one burst per macroblock
    // ------------------------------------------------------------------
    localparam int BEATS_PER_BURST = 4;
    localparam int BEAT_IDX_W      = $clog2(BEATS_PER_BURST);
    localparam int BURST_BYTES     = BEATS_PER_BURST * STRB_W;

    localparam logic [7:0] AWLEN_VAL  = 8'(BEATS_PER_BURST - 1);
    // 8 bytes per beat
    localparam logic [2:0] AWSIZE_VAL = 3'($clog2(STRB_W));

    // Fixed AXI codes
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    // Normal non-cacheable bufferable
    localparam logic [3:0] AXI_CACHE_BUF  = 4'b0011;
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    // ------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] base_addr;
        logic [CNT_W-1:0]  burst_count;
        logic [CNT_W-1:0]  beat_count;
        logic              valid_job;
    } job_plan_t;

    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic [7:0]        awlen;
    } aw_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] bid;
        logic [1:0]      bresp;
    } b_resp_t;

endpackage

// ==== hdl/waddr_channel.sv ====
// ----------------------------------------------------------------------
// AW execute block
// One INCR burst per macroblock, issued back to back
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module waddr_channel (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_wr_pkg::job_plan_t  plan,
    input  logic                   plan_start,
    output axi_wr_pkg::aw_beat_t   aw,
    output logic                   awvalid,
    input  logic                   awready
);

    logic [axi_wr_pkg::ADDR_W-1:0] addr_q;
    logic [axi_wr_pkg::CNT_W-1:0]  bursts_left;
    logic                          aw_hs;

    assign aw_hs = awvalid && awready;

    // ------------------------------------------------------------------
    // Burst counter and valid
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bursts_left <= '0;
            awvalid     <= 1'b0;
        end
        else if (plan_start)
        begin
            bursts_left <= plan.burst_count;
            awvalid     <= plan.burst_count != '0;
        end
        else if (aw_hs)
        begin
            bursts_left <= bursts_left - 1'b1;
            // Last burst accepted
            awvalid     <= bursts_left != axi_wr_pkg::CNT_W'(1);
        end
    end

    // Address advances one burst per handshake
    always_ff @(posedge clk)
    begin
        if (plan_start)
            addr_q <= plan.base_addr;
        else if (aw_hs)
            addr_q <= addr_q + axi_wr_pkg::ADDR_W'(axi_wr_pkg::BURST_BYTES);
    end

    assign aw.awaddr = addr_q;
    assign aw.awlen  = axi_wr_pkg::AWLEN_VAL;

    // Payload holds under back-pressure
    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw));

endmodule

// ==== hdl/wdata_channel.sv ====
// ----------------------------------------------------------------------
// W execute block
// Pops show-ahead FIFO words straight into write beats
// wlast on every fourth beat of the job
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module wdata_channel (
    input  logic                          clk,
    input  logic                          rst_n,
    input  axi_wr_pkg::job_plan_t         plan,
    input  logic                          plan_start,
    input  logic                          fifo_empty,
    input  logic [axi_wr_pkg::DATA_W-1:0] fifo_dout,
    output logic                          fifo_rd,
    output logic [axi_wr_pkg::DATA_W-1:0] wdata,
    output logic [axi_wr_pkg::STRB_W-1:0] wstrb,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready
);

    logic [axi_wr_pkg::CNT_W-1:0]      beats_left;
    logic [axi_wr_pkg::BEAT_IDX_W-1:0] beat_pos;
    logic                              active;
    logic                              w_hs;

    assign active = beats_left != '0;
    assign wvalid = active && !fifo_empty;
    assign w_hs   = wvalid && wready;

    // FIFO is show-ahead, so a pop is exactly a W handshake
    assign fifo_rd = w_hs;
    assign wdata   = fifo_dout;
    assign wstrb   = '1;
    assign wlast   = beat_pos == axi_wr_pkg::BEAT_IDX_W'(axi_wr_pkg::BEATS_PER_BURST - 1);

    // ------------------------------------------------------------------
    // Beat counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beats_left <= '0;
            beat_pos   <= '0;
        end
        else if (plan_start)
        begin
            beats_left <= plan.beat_count;
            beat_pos   <= '0;
        end
        else if (w_hs)
        begin
            beats_left <= beats_left - 1'b1;
            // Wraps at the burst size
            beat_pos   <= beat_pos + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    // A shown word stays on the bus until the slave takes it
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast));

    // wlast agrees with the beats sent so far in the job
    a_wlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> wlast == (((plan.beat_count - beats_left)
                            % axi_wr_pkg::BEATS_PER_BURST)
                           == axi_wr_pkg::BEATS_PER_BURST - 1));

endmodule

// ==== hdl/wr_job_decode.sv ====
// ----------------------------------------------------------------------
// Job decode stage
// Captures start_pulse jobs and turns the grid into a burst plan
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module wr_job_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_pulse,
    input  logic [axi_wr_pkg::ADDR_W-1:0]  target_address,
    input  logic [axi_wr_pkg::GRID_W-1:0]  blk_w,
    input  logic [axi_wr_pkg::GRID_W-1:0]  blk_h,
    input  logic                           busy,
    output axi_wr_pkg::job_plan_t          plan,
    output logic                           plan_start
);

    logic                             accept;
    logic [2*axi_wr_pkg::GRID_W-1:0]  blk_prod;
    logic [axi_wr_pkg::CNT_W-1:0]     burst_cnt;
    logic [axi_wr_pkg::CNT_W-1:0]     beat_cnt;
    logic                             busy_d;

    // Drop new jobs while one is in flight, and drop empty grids
    assign accept = start_pulse && !busy && !plan.valid_job
                    && (blk_w != '0) && (blk_h != '0);

    // Counts wrap past 2^18 macroblocks
    assign blk_prod  = blk_w * blk_h;
    assign burst_cnt = axi_wr_pkg::CNT_W'(blk_prod);
    assign beat_cnt  = axi_wr_pkg::CNT_W'(blk_prod * axi_wr_pkg::BEATS_PER_BURST);

    // ------------------------------------------------------------------
    // Plan register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            plan       <= '0;
            plan_start <= 1'b0;
            busy_d     <= 1'b0;
        end
        else
        begin
            busy_d     <= busy;
            plan_start <= accept;
            if (accept)
            begin
                plan.base_addr   <= target_address;
                plan.burst_count <= burst_cnt;
                plan.beat_count  <= beat_cnt;
                plan.valid_job   <= 1'b1;
            end
            // Job retires once the tracker drops busy
            else if (busy_d && !busy)
            begin
                plan.valid_job <= 1'b0;
            end
        end
    end

    // Base address must sit on a burst boundary
    a_base_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> target_address[$clog2(axi_wr_pkg::BURST_BYTES)-1:0] == '0);

endmodule

// ==== hdl/wresp_tracker.sv ====
// ----------------------------------------------------------------------
// B response tracker
// Counts responses, holds busy, flags done and error responses
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module wresp_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_wr_pkg::job_plan_t  plan,
    input  logic                   plan_start,
    input  axi_wr_pkg::b_resp_t    b,
    input  logic                   bvalid,
    output logic                   busy,
    output logic                   done_pulse,
    output logic                   wr_error
);

    logic [axi_wr_pkg::CNT_W-1:0] resp_left;
    logic                         last_resp;

    // bready is tied high, so every bvalid is a handshake
    assign last_resp = bvalid && (resp_left == axi_wr_pkg::CNT_W'(1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            resp_left  <= '0;
            busy       <= 1'b0;
            done_pulse <= 1'b0;
            wr_error   <= 1'b0;
        end
        else
        begin
            done_pulse <= last_resp;
            wr_error   <= bvalid && (b.bresp != axi_wr_pkg::AXI_RESP_OKAY);
            if (plan_start)
            begin
                resp_left <= plan.burst_count;
                busy      <= 1'b1;
            end
            else if (bvalid)
            begin
                resp_left <= resp_left - 1'b1;
                if (last_resp)
                    busy <= 1'b0;
            end
        end
    end

    // No response may arrive without a job in flight
    a_b_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> busy);

endmodule

// ==== sim.f ====
hdl/axi_wr_pkg.sv
hdl/wr_job_decode.sv
hdl/waddr_channel.sv
hdl/wdata_channel.sv
hdl/wresp_tracker.sv
hdl/axi_master_wr.sv
dv/axi_wr_mem_model.sv
dv/tb_axi_master_wr.sv
